//--- verilog/wb_bus_pkg.sv
// Wishbone B4 field widths, cycle type encoding
// and the byte-lane merge shared by the bus slaves
`default_nettype none

package wb_bus_pkg;

  // ==================================================
  // Bus widths
  // ==================================================
  localparam int WB_AW = 32;
  localparam int WB_DW = 32;
  // One select line per byte lane
  localparam int WB_SW = WB_DW / 8;

  // Cycle type identifier, B4 encoding
  typedef enum logic [2:0] {
    WB_CTI_CLASSIC = 3'b000,
    WB_CTI_CONST   = 3'b001,
    WB_CTI_INCR    = 3'b010,
    WB_CTI_EOB     = 3'b111
  } wb_cti_e;

  // Replace only the byte lanes flagged in sel
  function automatic logic [WB_DW-1:0] wb_merge_bytes(input logic [WB_DW-1:0] old_w,
                                                      input logic [WB_DW-1:0] new_w,
                                                      input logic [WB_SW-1:0] sel);
    logic [WB_DW-1:0] res;
    res = old_w;
    for (int b = 0; b < WB_SW; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

//--- verilog/soc_map_pkg.sv
// SoC address map: slave indices, region codes
// and timer register offsets
`default_nettype none

package soc_map_pkg;

  // ==================================================
  // Slaves behind the interconnect
  // ==================================================
  localparam int NUM_SLAVES = 3;

  typedef enum logic [1:0] {
    SLV_RAM   = 2'd0,
    SLV_CLINT = 2'd1,
    SLV_PBUS  = 2'd2
  } slave_idx_e;

  // Region codes, address bits 31..28
  localparam logic [3:0] REGION_RAM   = 4'h8;
  localparam logic [3:0] REGION_CLINT = 4'h3;
  localparam logic [3:0] REGION_PBUS  = 4'h2;

  // ==================================================
  // Timer block byte offsets
  // ==================================================
  localparam logic [3:0] TMR_MTIME_LO = 4'h0;
  localparam logic [3:0] TMR_MTIME_HI = 4'h4;
  localparam logic [3:0] TMR_CMP_LO   = 4'h8;
  localparam logic [3:0] TMR_CMP_HI   = 4'hC;

endpackage

`default_nettype wire

//--- verilog/wb_interconnect.sv
// Wishbone B4 pipelined 1-to-3 interconnect
// Region decode, request tracking, fan-out and response mux
`timescale 1ns/10ps
`default_nettype none

module wb_interconnect
  import wb_bus_pkg::*;
  import soc_map_pkg::*;
(
  input  wire logic                             clk_i,
  input  wire logic                             rst_ni,
  // Master side
  input  wire logic                             m_cyc_i,
  input  wire logic                             m_stb_i,
  input  wire logic                             m_we_i,
  input  wire logic [WB_AW-1:0]                 m_adr_i,
  input  wire logic [WB_DW-1:0]                 m_dat_i,
  input  wire logic [WB_SW-1:0]                 m_sel_i,
  input  wire wb_cti_e                          m_cti_i,
  output logic      [WB_DW-1:0]                 m_dat_o,
  output logic                                  m_ack_o,
  output logic                                  m_err_o,
  output logic                                  m_stall_o,
  // Slave side
  output logic      [NUM_SLAVES-1:0]            s_cyc_o,
  output logic      [NUM_SLAVES-1:0]            s_stb_o,
  output logic      [WB_AW-1:0]                 s_adr_o,
  output logic      [WB_DW-1:0]                 s_dat_o,
  output logic      [WB_SW-1:0]                 s_sel_o,
  output logic                                  s_we_o,
  input  wire logic [NUM_SLAVES-1:0][WB_DW-1:0] s_dat_i,
  input  wire logic [NUM_SLAVES-1:0]            s_ack_i,
  input  wire logic [NUM_SLAVES-1:0]            s_err_i,
  input  wire logic [NUM_SLAVES-1:0]            s_stall_i
);

  // ==================================================
  // Address decode
  // ==================================================
  logic [NUM_SLAVES-1:0] dec_sel;
  slave_idx_e            dec_idx;
  logic                  addr_valid;

  always_comb begin
    dec_sel    = '0;
    dec_idx    = SLV_RAM;
    addr_valid = 1'b1;
    case (m_adr_i[31:28])
      REGION_RAM:   dec_idx = SLV_RAM;
      REGION_CLINT: dec_idx = SLV_CLINT;
      REGION_PBUS:  dec_idx = SLV_PBUS;
      default:      addr_valid = 1'b0;
    endcase
    // One-hot select only for mapped regions
    if (addr_valid) begin
      dec_sel[dec_idx] = 1'b1;
    end
  end

  // ==================================================
  // Request tracking
  // ==================================================
  slave_idx_e active_q;
  wb_cti_e    last_cti_q;
  logic       pending_q;
  logic       req;
  logic       accept;
  logic       resp;

  assign req    = m_cyc_i && m_stb_i;
  // Unmapped requests never reach a slave, so they are not tracked
  assign accept = req && addr_valid && !m_stall_o;
  // All slaves answer at most one cycle after acceptance
  assign resp   = pending_q && (s_ack_i[active_q] || s_err_i[active_q]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q   <= SLV_RAM;
      last_cti_q <= WB_CTI_CLASSIC;
      pending_q  <= 1'b0;
    end else if (accept) begin
      active_q   <= dec_idx;
      last_cti_q <= m_cti_i;
      pending_q  <= 1'b1;
    end else if (resp) begin
      // Burst finished once its last request is answered
      if (last_cti_q == WB_CTI_CLASSIC || last_cti_q == WB_CTI_EOB) begin
        pending_q <= 1'b0;
      end
    end
  end

  // ==================================================
  // Request fan-out
  // ==================================================
  assign s_adr_o = m_adr_i;
  assign s_dat_o = m_dat_i;
  assign s_sel_o = m_sel_i;
  assign s_we_o  = m_we_i;

  always_comb begin
    for (int i = 0; i < NUM_SLAVES; i++) begin
      s_stb_o[i] = req && dec_sel[i];
      // Hold cyc to the tracked slave until its response is back
      s_cyc_o[i] = m_cyc_i && (dec_sel[i] || (pending_q && active_q == slave_idx_e'(i)));
    end
  end

  // ==================================================
  // Response mux
  // ==================================================
  // Stall follows the strobed slave; unmapped requests wait out a pending response
  assign m_stall_o = req && (addr_valid ? s_stall_i[dec_idx] : pending_q);

  always_comb begin
    m_dat_o = s_dat_i[active_q];
    m_ack_o = pending_q && s_ack_i[active_q];
    m_err_o = pending_q && s_err_i[active_q];
    // Immediate error for an unmapped strobe
    if (req && !addr_valid && !pending_q) begin
      m_err_o = 1'b1;
    end
  end

  // ==================================================
  // Assertions
  // ==================================================
  // Slaves only answer while a request is tracked
  a_resp_tracked: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|(s_ack_i | s_err_i)) |-> pending_q);

  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(m_ack_o && m_err_o));

endmodule

`default_nettype wire

//--- verilog/wb_ram_slave.sv
// Wishbone B4 pipelined RAM slave
// Byte-writable word memory, ack one cycle after acceptance
`timescale 1ns/10ps
`default_nettype none

module wb_ram_slave
  import wb_bus_pkg::*;
#(
  parameter int unsigned RAM_WORDS = 1024
) (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             cyc_i,
  input  wire logic             stb_i,
  input  wire logic             we_i,
  input  wire logic [WB_AW-1:0] adr_i,
  input  wire logic [WB_DW-1:0] dat_i,
  input  wire logic [WB_SW-1:0] sel_i,
  output logic      [WB_DW-1:0] dat_o,
  output logic                  ack_o,
  output logic                  err_o,
  output logic                  stall_o
);

  localparam int IDX_W = $clog2(RAM_WORDS);

  logic [WB_DW-1:0] mem [RAM_WORDS];
  logic [IDX_W-1:0] word_idx;
  logic             accept;

  // Word address, upper bits wrap around the array
  assign word_idx = adr_i[IDX_W+1:2];
  // Never stalls, so every strobe is taken
  assign accept   = cyc_i && stb_i;

  // ==================================================
  // Memory array and read register
  // ==================================================
  always_ff @(posedge clk_i) begin
    if (accept && we_i) begin
      mem[word_idx] <= wb_merge_bytes(mem[word_idx], dat_i, sel_i);
    end
    // Read data captured on every accept
    if (accept) begin
      dat_o <= mem[word_idx];
    end
  end

  // Pipelined acknowledge, one per accepted request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= accept;
    end
  end

  assign err_o   = 1'b0;
  assign stall_o = 1'b0;

  // Strobe only inside a bus cycle
  a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stb_i |-> cyc_i);

endmodule

`default_nettype wire

//--- verilog/wb_timer_slave.sv
// Core-local timer slave: 64-bit mtime and mtimecmp
// Registered timer interrupt, one stall cycle per strobe
`timescale 1ns/10ps
`default_nettype none

module wb_timer_slave
  import wb_bus_pkg::*;
  import soc_map_pkg::*;
(
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             cyc_i,
  input  wire logic             stb_i,
  input  wire logic             we_i,
  input  wire logic [WB_AW-1:0] adr_i,
  input  wire logic [WB_DW-1:0] dat_i,
  input  wire logic [WB_SW-1:0] sel_i,
  output logic      [WB_DW-1:0] dat_o,
  output logic                  ack_o,
  output logic                  err_o,
  output logic                  stall_o,
  output logic                  timer_irq_o
);

  typedef enum logic {
    TMR_IDLE,
    TMR_WAIT
  } tmr_state_e;

  tmr_state_e state_q;
  logic [63:0] mtime_q;
  logic [63:0] mtimecmp_q;
  logic [3:0]  off;
  logic        off_valid;
  logic        accept;

  // ==================================================
  // Bus handshake
  // ==================================================
  assign off       = adr_i[3:0];
  // Only word offsets 0x0..0xC inside the region
  assign off_valid = (adr_i[27:4] == '0) && (adr_i[1:0] == 2'b00);
  // First cycle of a strobe always stalls
  assign stall_o   = (state_q == TMR_IDLE) && cyc_i && stb_i;
  assign accept    = (state_q == TMR_WAIT) && cyc_i && stb_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= TMR_IDLE;
      ack_o   <= 1'b0;
      err_o   <= 1'b0;
    end else begin
      case (state_q)
        TMR_IDLE: if (cyc_i && stb_i) state_q <= TMR_WAIT;
        default:  state_q <= TMR_IDLE;
      endcase
      ack_o <= accept && off_valid;
      err_o <= accept && !off_valid;
    end
  end

  // Read data for the accepted offset
  always_ff @(posedge clk_i) begin
    if (accept) begin
      case (off)
        TMR_MTIME_LO: dat_o <= mtime_q[31:0];
        TMR_MTIME_HI: dat_o <= mtime_q[63:32];
        TMR_CMP_LO:   dat_o <= mtimecmp_q[31:0];
        TMR_CMP_HI:   dat_o <= mtimecmp_q[63:32];
        default:      dat_o <= '0;
      endcase
    end
  end

  // ==================================================
  // Counter, compare and interrupt
  // ==================================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      timer_irq_o <= 1'b0;
    end else begin
      mtime_q     <= mtime_q + 64'd1;
      timer_irq_o <= (mtime_q >= mtimecmp_q);
      // A write to a half overrides the increment for that half
      if (accept && we_i && off_valid) begin
        case (off)
          TMR_MTIME_LO: mtime_q[31:0]     <= wb_merge_bytes(mtime_q[31:0], dat_i, sel_i);
          TMR_MTIME_HI: mtime_q[63:32]    <= wb_merge_bytes(mtime_q[63:32], dat_i, sel_i);
          TMR_CMP_LO:   mtimecmp_q[31:0]  <= wb_merge_bytes(mtimecmp_q[31:0], dat_i, sel_i);
          TMR_CMP_HI:   mtimecmp_q[63:32] <= wb_merge_bytes(mtimecmp_q[63:32], dat_i, sel_i);
          default:      mtimecmp_q        <= mtimecmp_q;
        endcase
      end
    end
  end

  // Request fields stay put while the strobe is stalled
  a_stall_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall_o |=> (!(cyc_i && stb_i) ||
                 ($stable(adr_i) && $stable(we_i) && $stable(dat_i) && $stable(sel_i))));

endmodule

`default_nettype wire

//--- verilog/wb_subsys_top.sv
// Wishbone subsystem top level
// Interconnect, main RAM, peripheral scratch RAM and timer
`timescale 1ns/10ps
`default_nettype none

module wb_subsys_top
  import wb_bus_pkg::*;
  import soc_map_pkg::*;
(
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  // External master port
  input  wire logic             wb_cyc_i,
  input  wire logic             wb_stb_i,
  input  wire logic             wb_we_i,
  input  wire logic [WB_AW-1:0] wb_adr_i,
  input  wire logic [WB_DW-1:0] wb_dat_i,
  input  wire logic [WB_SW-1:0] wb_sel_i,
  input  wire wb_cti_e          wb_cti_i,
  // Burst type, no wrap support so it goes nowhere
  input  wire logic [1:0]       wb_bte_i,
  output logic      [WB_DW-1:0] wb_dat_o,
  output logic                  wb_ack_o,
  output logic                  wb_err_o,
  output logic                  wb_stall_o,
  output logic                  timer_irq_o
);

  // ==================================================
  // Slave bus wires
  // ==================================================
  logic [NUM_SLAVES-1:0]            s_cyc;
  logic [NUM_SLAVES-1:0]            s_stb;
  logic [WB_AW-1:0]                 s_adr;
  logic [WB_DW-1:0]                 s_wdat;
  logic [WB_SW-1:0]                 s_sel;
  logic                             s_we;
  logic [NUM_SLAVES-1:0][WB_DW-1:0] s_rdat;
  logic [NUM_SLAVES-1:0]            s_ack;
  logic [NUM_SLAVES-1:0]            s_err;
  logic [NUM_SLAVES-1:0]            s_stall;

  wb_interconnect u_icon (
    .clk_i, .rst_ni,
    .m_cyc_i (wb_cyc_i), .m_stb_i (wb_stb_i), .m_we_i (wb_we_i),
    .m_adr_i (wb_adr_i), .m_dat_i (wb_dat_i), .m_sel_i (wb_sel_i),
    .m_cti_i (wb_cti_i),
    .m_dat_o (wb_dat_o), .m_ack_o (wb_ack_o), .m_err_o (wb_err_o),
    .m_stall_o (wb_stall_o),
    .s_cyc_o (s_cyc), .s_stb_o (s_stb), .s_adr_o (s_adr),
    .s_dat_o (s_wdat), .s_sel_o (s_sel), .s_we_o (s_we),
    .s_dat_i (s_rdat), .s_ack_i (s_ack), .s_err_i (s_err), .s_stall_i (s_stall)
  );

  // Main memory at 0x8xxx_xxxx
  wb_ram_slave #(.RAM_WORDS(1024)) u_ram (
    .clk_i, .rst_ni,
    .cyc_i (s_cyc[SLV_RAM]), .stb_i (s_stb[SLV_RAM]), .we_i (s_we),
    .adr_i (s_adr), .dat_i (s_wdat), .sel_i (s_sel),
    .dat_o (s_rdat[SLV_RAM]), .ack_o (s_ack[SLV_RAM]),
    .err_o (s_err[SLV_RAM]), .stall_o (s_stall[SLV_RAM])
  );

  // Peripheral bus stand-in at 0x2xxx_xxxx
  wb_ram_slave #(.RAM_WORDS(256)) u_pbus (
    .clk_i, .rst_ni,
    .cyc_i (s_cyc[SLV_PBUS]), .stb_i (s_stb[SLV_PBUS]), .we_i (s_we),
    .adr_i (s_adr), .dat_i (s_wdat), .sel_i (s_sel),
    .dat_o (s_rdat[SLV_PBUS]), .ack_o (s_ack[SLV_PBUS]),
    .err_o (s_err[SLV_PBUS]), .stall_o (s_stall[SLV_PBUS])
  );

  // Core-local timer at 0x3xxx_xxxx
  wb_timer_slave u_clint (
    .clk_i, .rst_ni,
    .cyc_i (s_cyc[SLV_CLINT]), .stb_i (s_stb[SLV_CLINT]), .we_i (s_we),
    .adr_i (s_adr), .dat_i (s_wdat), .sel_i (s_sel),
    .dat_o (s_rdat[SLV_CLINT]), .ack_o (s_ack[SLV_CLINT]),
    .err_o (s_err[SLV_CLINT]), .stall_o (s_stall[SLV_CLINT]),
    .timer_irq_o
  );

endmodule

`default_nettype wire

//--- tb/tb_wb_subsys.sv
// Testbench for the Wishbone subsystem top level
// Pattern-driven request driver, in-order response monitor,
// byte-lane reference model and watchdog
`timescale 1ns/10ps
`default_nettype none

module tb_wb_subsys
  import wb_bus_pkg::*;
();

  localparam int CLK_PERIOD   = 10;
  localparam int MAX_LINES    = 64;
  localparam int N_COLS       = 7;
  localparam int RESP_TIMEOUT = 20;
  localparam int IRQ_IDLE     = 4;
  localparam int WDOG_PER_LINE = 200;

  // Pattern columns
  localparam int C_CMD   = 0;
  localparam int C_ADR   = 1;
  localparam int C_DAT   = 2;
  localparam int C_SEL   = 3;
  localparam int C_BURST = 4;
  localparam int C_RESP  = 5;
  localparam int C_EXP   = 6;

  // Command codes
  localparam logic [31:0] CMD_READ  = 32'h1;
  localparam logic [31:0] CMD_WRITE = 32'h2;
  localparam logic [31:0] CMD_IRQ   = 32'h3;
  localparam logic [31:0] CMD_END   = 32'hF;
  localparam logic [31:0] RESP_ERR  = 32'h1;

  logic        clk_i;
  logic        rst_ni;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic [31:0] wb_adr_i;
  logic [31:0] wb_dat_i;
  logic [3:0]  wb_sel_i;
  wb_cti_e     wb_cti_i;
  logic [1:0]  wb_bte_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack_o;
  logic        wb_err_o;
  logic        wb_stall_o;
  logic        timer_irq_o;

  logic [31:0] pat_mem [0:MAX_LINES*N_COLS-1];
  int          n_lines;
  int          n_errors;
  int          n_checks;
  int          cur_idx;
  logic        req_taken;

  // Outstanding requests, oldest first
  int          exp_idx_q[$];
  logic [31:0] exp_dat_q[$];
  // Expected memory and register contents by byte address
  logic [31:0] model_mem [logic [31:0]];

  wb_subsys_top dut0 (
    .clk_i, .rst_ni,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_sel_i,
    .wb_cti_i, .wb_bte_i,
    .wb_dat_o, .wb_ack_o, .wb_err_o, .wb_stall_o,
    .timer_irq_o
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ==================================================
  // Helpers
  // ==================================================
  function automatic logic [31:0] pat(input int line, input int col);
    return pat_mem[line*N_COLS + col];
  endfunction

  // Byte lanes flagged in sel take the new data
  function automatic logic [31:0] apply_sel(input logic [31:0] old_w,
                                            input logic [31:0] new_w,
                                            input logic [3:0]  sel);
    logic [31:0] mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  task automatic expect_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERROR: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // ==================================================
  // Monitor: acceptance and in-order responses
  // ==================================================
  task automatic sample_bus();
    logic [31:0] exp_d;
    logic [31:0] old_w;
    logic        exp_err;
    int          idx;
    req_taken = wb_cyc_i && wb_stb_i && !wb_stall_o;
    if (req_taken) begin
      exp_d = pat(cur_idx, C_EXP);
      if (wb_we_i && pat(cur_idx, C_RESP) != RESP_ERR) begin
        old_w = model_mem.exists(wb_adr_i) ? model_mem[wb_adr_i] : 32'h0;
        model_mem[wb_adr_i] = apply_sel(old_w, wb_dat_i, wb_sel_i);
      end else if (!wb_we_i && model_mem.exists(wb_adr_i)) begin
        // File value must agree with what the model holds
        if (pat(cur_idx, C_RESP) != RESP_ERR && model_mem[wb_adr_i] !== exp_d) begin
          n_errors++;
          $display("Pattern %0d expects %h but the reference model holds %h",
                   cur_idx, exp_d, model_mem[wb_adr_i]);
        end
        exp_d = model_mem[wb_adr_i];
      end
      exp_idx_q.push_back(cur_idx);
      exp_dat_q.push_back(exp_d);
    end
    // Unmapped err arrives in the acceptance cycle, so after the push
    if (wb_ack_o || wb_err_o) begin
      if (exp_idx_q.size() == 0) begin
        n_errors++;
        $display("Response seen with no request outstanding at %0t", $time);
      end else begin
        idx     = exp_idx_q.pop_front();
        exp_d   = exp_dat_q.pop_front();
        exp_err = (pat(idx, C_RESP) == RESP_ERR);
        n_checks++;
        if (wb_ack_o && wb_err_o) begin
          n_errors++;
          $display("Protocol problem: ack and err high together for pattern %0d", idx);
        end else if (wb_err_o !== exp_err) begin
          n_errors++;
          $display("ERROR: wb_err_o got %h expected %h at pattern %0d",
                   wb_err_o, exp_err, idx);
        end else if (!exp_err && pat(idx, C_CMD) == CMD_READ && wb_dat_o !== exp_d) begin
          n_errors++;
          $display("ERROR: wb_dat_o got %h expected %h at pattern %0d",
                   wb_dat_o, exp_d, idx);
        end
      end
    end
  endtask

  always @(posedge clk_i) begin
    sample_bus();
  end

  // ==================================================
  // Driver
  // ==================================================
  // Called on a falling edge; returns on the falling edge after acceptance
  task automatic drive_request(input int idx, input wb_cti_e cti);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = (pat(idx, C_CMD) == CMD_WRITE);
    wb_adr_i = pat(idx, C_ADR);
    wb_dat_i = pat(idx, C_DAT);
    wb_sel_i = 4'(pat(idx, C_SEL));
    wb_cti_i = cti;
    cur_idx  = idx;
    // Fields held while stalled
    do begin
      @(negedge clk_i);
    end while (!req_taken);
  endtask

  // One cyc: a single access or a whole burst
  task automatic run_cycle(input int first, output int next);
    int      idx;
    int      wait_cnt;
    logic    in_burst;
    wb_cti_e cti;
    idx      = first;
    in_burst = (pat(first, C_BURST) != 0);
    @(negedge clk_i);
    do begin
      if (pat(idx, C_BURST) != 0) begin
        cti = WB_CTI_INCR;
      end else if (in_burst) begin
        cti = WB_CTI_EOB;
      end else begin
        cti = WB_CTI_CLASSIC;
      end
      drive_request(idx, cti);
      idx++;
    end while (pat(idx - 1, C_BURST) != 0 && idx < n_lines);
    wb_stb_i = 1'b0;
    // cyc stays up until every response is back
    wait_cnt = 0;
    while (exp_idx_q.size() != 0 && wait_cnt < RESP_TIMEOUT) begin
      @(negedge clk_i);
      wait_cnt++;
    end
    if (exp_idx_q.size() != 0) begin
      n_errors++;
      $display("No response to pattern %0d within %0d cycles", exp_idx_q[0], RESP_TIMEOUT);
      exp_idx_q.delete();
      exp_dat_q.delete();
    end
    wb_cyc_i = 1'b0;
    wb_cti_i = WB_CTI_CLASSIC;
    next     = idx;
  endtask

  task automatic check_irq(input int idx);
    repeat (IRQ_IDLE) @(negedge clk_i);
    expect_bit("timer_irq_o", timer_irq_o, pat(idx, C_EXP) != 0);
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    int line;
    clk_i    = 1'b0;
    rst_ni   = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    wb_cti_i = WB_CTI_CLASSIC;
    wb_bte_i = 2'b00;
    cur_idx   = 0;
    req_taken = 1'b0;
    n_errors  = 0;
    n_checks  = 0;
    $readmemh("tb/wb_patterns.txt", pat_mem);
    n_lines = 0;
    while (n_lines < MAX_LINES && pat(n_lines, C_CMD) != CMD_END) begin
      n_lines++;
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    // Idle outputs before the first request
    @(negedge clk_i);
    expect_bit("wb_ack_o", wb_ack_o, 1'b0);
    expect_bit("wb_err_o", wb_err_o, 1'b0);
    expect_bit("wb_stall_o", wb_stall_o, 1'b0);
    expect_bit("timer_irq_o", timer_irq_o, 1'b0);
    line = 0;
    while (line < n_lines) begin
      if (pat(line, C_CMD) == CMD_IRQ) begin
        check_irq(line);
        line++;
      end else if (pat(line, C_CMD) == CMD_READ || pat(line, C_CMD) == CMD_WRITE) begin
        run_cycle(line, line);
      end else begin
        n_errors++;
        $display("Unknown command %h on pattern %0d", pat(line, C_CMD), line);
        line++;
      end
    end
    repeat (2) @(negedge clk_i);
    $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog scaled to the pattern count
  initial begin
    #1;
    repeat ((n_lines + 2) * WDOG_PER_LINE) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, run stopped",
             (n_lines + 2) * WDOG_PER_LINE);
    $display("Summary: %0d checks, %0d errors", n_checks, n_errors + 1);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/wb_patterns.txt
// cmd addr data sel burst resp exp  (all hex)
// cmd 1 read, 2 write, 3 irq level after idle, F end; burst 1 continue 0 last; resp 0 ack 1 err
2 80000000 11223344 f 0 0 0
2 80000004 a5a5a5a5 f 0 0 0
2 80000000 000000cc 1 0 0 0
2 80000000 ee000000 8 0 0 0
2 80000004 00beef00 6 0 0 0
1 80000000 00000000 f 0 0 ee2233cc
1 80000004 00000000 f 0 0 a5beefa5
2 20000000 cafef00d f 0 0 0
1 20000000 00000000 f 0 0 cafef00d
1 80000000 00000000 f 0 0 ee2233cc
2 00000000 12345678 f 0 1 0
1 f0000000 00000000 f 0 1 0
1 80000004 00000000 f 0 0 a5beefa5
2 80000100 b0000000 f 1 0 0
2 80000104 b1000001 f 1 0 0
2 80000108 b2000002 f 1 0 0
2 8000010c b3000003 f 1 0 0
2 80000110 b4000004 f 1 0 0
2 80000114 b5000005 f 1 0 0
2 80000118 b6000006 f 1 0 0
2 8000011c b7000007 f 0 0 0
1 80000100 00000000 f 1 0 b0000000
1 80000104 00000000 f 1 0 b1000001
1 80000108 00000000 f 1 0 b2000002
1 8000010c 00000000 f 1 0 b3000003
1 80000110 00000000 f 1 0 b4000004
1 80000114 00000000 f 1 0 b5000005
1 80000118 00000000 f 1 0 b6000006
1 8000011c 00000000 f 0 0 b7000007
1 30000008 00000000 f 0 0 ffffffff
2 30000008 00000000 f 0 0 0
2 3000000c 00000000 f 0 0 0
3 00000000 00000000 0 0 0 1
1 30000008 00000000 f 0 0 00000000
1 3000000c 00000000 f 0 0 00000000
2 3000000c ffffffff f 0 0 0
2 30000008 ffffffff f 0 0 0
3 00000000 00000000 0 0 0 0
1 30000008 00000000 f 0 0 ffffffff
1 3000000c 00000000 f 0 0 ffffffff
1 30000010 00000000 f 0 1 0
F 00000000 00000000 0 0 0 0

//--- project.f
verilog/wb_bus_pkg.sv
verilog/soc_map_pkg.sv
verilog/wb_interconnect.sv
verilog/wb_ram_slave.sv
verilog/wb_timer_slave.sv
verilog/wb_subsys_top.sv
tb/tb_wb_subsys.sv

//--- Makefile
# Verilator build and run of the Wishbone subsystem testbench
SRCS := $(shell grep -v '^+' project.f)

obj_dir/Vtb_wb_subsys: project.f $(SRCS)
	verilator --binary --assert --timescale 1ns/10ps --top-module tb_wb_subsys -f project.f

run: obj_dir/Vtb_wb_subsys
	./obj_dir/Vtb_wb_subsys | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
